// ==== Bender.yml ====
package:
  name: rtx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rt_math_pkg.sv
      - rt_scene_pkg.sv
      - rtx_if.sv
      - ray_caster.sv
      - sphere_intersect.sv
      - pipe_delay.sv
      - trace_ctrl.sv
      - pixel_pack.sv
      - rtx_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rtx.sv

// ==== list.f ====
+incdir+.
rt_math_pkg.sv
rt_scene_pkg.sv
rtx_if.sv
ray_caster.sv
sphere_intersect.sv
pipe_delay.sv
trace_ctrl.sv
pixel_pack.sv
rtx_top.sv
tb_rtx.sv

// ==== pipe_delay.sv ====
`default_nettype none

module pipe_delay #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  T     in_data,
  output logic out_valid,
  output T     out_data
);

  logic [DEPTH-1:0] vld;
  T                 data [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else begin
      vld[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        vld[i] <= vld[i-1];
      end
    end
  end

  // payload shifts every cycle, a held input settles after DEPTH cycles
  always_ff @(posedge clk) begin
    data[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data[i] <= data[i-1];
    end
  end

  assign out_valid = vld[DEPTH-1];
  assign out_data  = data[DEPTH-1];

endmodule

`default_nettype wire

// ==== pixel_pack.sv ====
`default_nettype none

`include "rtx_config.svh"

module pixel_pack (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 res_valid,
  input  logic                 res_hit,
  input  rt_scene_pkg::color_t res_color,
  input  rt_scene_pkg::pix_t   pix_in,
  output logic [15:0]          rtx_pixel,
  output rt_scene_pkg::pix_t   pix_out,
  output logic                 ray_done
);
  import rt_scene_pkg::*;

  color_t sel;

  // miss falls back to the sky color
  assign sel = res_hit ? res_color : color_t'(`RTX_BG_COLOR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ray_done <= 1'b0;
    end else begin
      ray_done <= res_valid;
    end
  end

  // red in the low bits, blue on top
  always_ff @(posedge clk) begin
    if (res_valid) begin
      rtx_pixel <= {sel.b[7:3], sel.g[7:2], sel.r[7:3]};
      pix_out   <= pix_in;
    end
  end

endmodule

`default_nettype wire

// ==== ray_caster.sv ====
`default_nettype none

`include "rtx_config.svh"

module ray_caster #(
  parameter int WIDTH  = `RTX_WIDTH,
  parameter int HEIGHT = `RTX_HEIGHT
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rt_scene_pkg::camera_t cam,
  input  logic                  new_ray,
  ray_if.source                 ray
);
  import rt_math_pkg::*;
  import rt_scene_pkg::*;

  // current pixel, advanced after each issued ray
  pix_t  cnt;
  vec3_t dir;
  logic  last_col;
  logic  last_row;

  assign last_col = (cnt.h == 11'(WIDTH - 1));
  assign last_row = (cnt.v == 10'(HEIGHT - 1));

  // screen center maps to the optical axis, +y points up
  always_comb begin
    dir.x = coord_t'(cnt.h) - coord_t'(WIDTH / 2);
    dir.y = coord_t'(HEIGHT / 2) - coord_t'(cnt.v);
    dir.z = coord_t'(cam.focal);
  end

  // raster counters and ray strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      ray.valid <= 1'b0;
    end else begin
      ray.valid <= new_ray;
      if (new_ray) begin
        if (last_col) begin
          cnt.h <= '0;
          // wrap to the top left after the last row
          cnt.v <= last_row ? '0 : cnt.v + 10'd1;
        end else begin
          cnt.h <= cnt.h + 11'd1;
        end
      end
    end
  end

  // ray payload, captured together with the strobe
  always_ff @(posedge clk) begin
    if (new_ray) begin
      ray.pix    <= cnt;
      ray.origin <= cam.pos;
      ray.dir    <= dir;
    end
  end

endmodule

`default_nettype wire

// ==== rt_math_pkg.sv ====
`default_nettype none

`include "rtx_config.svh"

package rt_math_pkg;

  // signed fixed-point scene coordinate
  typedef logic signed [`RTX_COORD_W-1:0] coord_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vec3_t;

  // sum of three coord products, 2 guard bits over a single product
  localparam int DOT_W = 2 * `RTX_COORD_W + 2;

  typedef logic signed [DOT_W-1:0] dot_t;

  // product of two dot values, used by the discriminant
  typedef logic signed [2*DOT_W-1:0] wide_t;

  // full precision dot product of two vectors
  function automatic dot_t dot3(vec3_t a, vec3_t b);
    return dot_t'(a.x) * dot_t'(b.x) + dot_t'(a.y) * dot_t'(b.y) + dot_t'(a.z) * dot_t'(b.z);
  endfunction

  // widen both operands before multiplying so nothing is lost
  function automatic wide_t mul_wide(dot_t a, dot_t b);
    return wide_t'(a) * wide_t'(b);
  endfunction

endpackage

`default_nettype wire

// ==== rt_scene_pkg.sv ====
`default_nettype none

`include "rtx_config.svh"

package rt_scene_pkg;

  // camera position and focal length in scene units
  typedef struct packed {
    rt_math_pkg::vec3_t pos;
    logic [11:0]        focal;
  } camera_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } color_t;

  // one scene buffer entry
  typedef struct packed {
    rt_math_pkg::vec3_t center;
    logic [11:0]        radius;
    color_t             color;
  } sphere_t;

  // screen coordinates, h is the column, v the row
  typedef struct packed {
    logic [10:0] h;
    logic [9:0]  v;
  } pix_t;

  localparam int OBJ_IDX_W = $clog2(`RTX_MAX_OBJS);

  typedef logic [OBJ_IDX_W-1:0] obj_idx_t;

  // object count, one bit wider so a full buffer fits
  typedef logic [OBJ_IDX_W:0] obj_cnt_t;

endpackage

`default_nettype wire

// ==== rtx_config.svh ====
`ifndef RTX_CONFIG_SVH
`define RTX_CONFIG_SVH

// default screen size in pixels
`define RTX_WIDTH 1280
`define RTX_HEIGHT 720

// signed scene coordinate width
// dot products and discriminant widths follow from this
`define RTX_COORD_W 12

// scene buffer depth, kept a power of two
`define RTX_MAX_OBJS 8

// RGB888 color of a ray that misses every object
// dark blue-grey sky
`define RTX_BG_COLOR 24'h203040

`endif

// ==== rtx_if.sv ====
`default_nettype none

// primary ray from the caster to the controller and intersector
interface ray_if;
  // one cycle strobe, the other fields hold until the next one
  logic                 valid;
  rt_scene_pkg::pix_t   pix;
  rt_math_pkg::vec3_t   origin;
  rt_math_pkg::vec3_t   dir;

  modport source (output valid, pix, origin, dir);
  modport sink   (input valid, pix, origin, dir);
endinterface

// per object test result from the intersector
interface hit_if;
  // one strobe for every object issued
  logic                  valid;
  logic                  hit;
  // L.L of the center, used as the distance key
  rt_math_pkg::dot_t     dist2;
  rt_scene_pkg::color_t  color;

  modport source (output valid, hit, dist2, color);
  modport sink   (input valid, hit, dist2, color);
endinterface

`default_nettype wire

// ==== rtx_top.sv ====
`default_nettype none

`include "rtx_config.svh"

module rtx_top #(
  parameter int WIDTH  = `RTX_WIDTH,
  parameter int HEIGHT = `RTX_HEIGHT
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rt_scene_pkg::camera_t  cam,
  input  rt_scene_pkg::obj_cnt_t num_objs,
  input  rt_scene_pkg::sphere_t  obj,
  output rt_scene_pkg::obj_idx_t obj_idx,
  output logic [15:0]            rtx_pixel,
  output logic [10:0]            pixel_h,
  output logic [9:0]             pixel_v,
  output logic                   ray_done
);
  import rt_scene_pkg::*;

  // final shade of one pixel on its way to the packer
  typedef struct packed {
    logic   hit;
    color_t color;
  } res_t;

  ray_if ray_bus ();
  hit_if hit_bus ();

  logic   new_ray;
  logic   obj_valid;
  logic   res_valid;
  logic   res_hit;
  color_t res_color;
  res_t   res_out;
  logic   res_out_valid;
  pix_t   pix_d;
  pix_t   pix_out;

  ray_caster #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_ray_caster (
    .clk(clk), .rst_n(rst_n), .cam(cam), .new_ray(new_ray), .ray(ray_bus)
  );

  trace_ctrl u_trace_ctrl (
    .clk(clk), .rst_n(rst_n), .num_objs(num_objs), .ray(ray_bus), .hit(hit_bus),
    .obj_idx(obj_idx), .obj_valid(obj_valid), .new_ray(new_ray),
    .res_valid(res_valid), .res_hit(res_hit), .res_color(res_color)
  );

  // objects come back from the scene buffer one cycle after obj_idx
  sphere_intersect u_sphere_intersect (
    .clk(clk), .rst_n(rst_n), .ray_dir(ray_bus.dir), .ray_origin(ray_bus.origin),
    .obj(obj), .obj_valid(obj_valid), .hit(hit_bus)
  );

  // pixel coordinates past object fetch and intersector
  pipe_delay #(.T(pix_t), .DEPTH(5)) u_pix_delay (
    .clk(clk), .rst_n(rst_n), .in_valid(ray_bus.valid), .in_data(ray_bus.pix),
    .out_valid(), .out_data(pix_d)
  );

  // hit flag and color into the packer stage
  pipe_delay #(.T(res_t), .DEPTH(1)) u_res_delay (
    .clk(clk), .rst_n(rst_n), .in_valid(res_valid), .in_data('{res_hit, res_color}),
    .out_valid(res_out_valid), .out_data(res_out)
  );

  pixel_pack u_pixel_pack (
    .clk(clk), .rst_n(rst_n), .res_valid(res_out_valid), .res_hit(res_out.hit),
    .res_color(res_out.color), .pix_in(pix_d), .rtx_pixel(rtx_pixel),
    .pix_out(pix_out), .ray_done(ray_done)
  );

  assign pixel_h = pix_out.h;
  assign pixel_v = pix_out.v;

endmodule

`default_nettype wire

// ==== sphere_intersect.sv ====
`default_nettype none

module sphere_intersect (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rt_math_pkg::vec3_t    ray_dir,
  input  rt_math_pkg::vec3_t    ray_origin,
  input  rt_scene_pkg::sphere_t obj,
  input  logic                  obj_valid,
  hit_if.source                 hit
);
  import rt_math_pkg::*;
  import rt_scene_pkg::*;

  // stage 1: L = center - origin
  logic        s1_valid;
  vec3_t       s1_l;
  logic [11:0] s1_r;
  color_t      s1_color;

  // stage 2: dot products and r squared
  logic        s2_valid;
  dot_t        s2_tca;
  dot_t        s2_dd;
  dot_t        s2_ll;
  dot_t        s2_r2;
  color_t      s2_color;

  // stage 3: wide products of the discriminant
  logic        s3_valid;
  logic        s3_tca_pos;
  wide_t       s3_tca2;
  wide_t       s3_cdd;
  dot_t        s3_ll;
  color_t      s3_color;

  // valid bits walk alongside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      s3_valid  <= 1'b0;
      hit.valid <= 1'b0;
    end else begin
      s1_valid  <= obj_valid;
      s2_valid  <= s1_valid;
      s3_valid  <= s2_valid;
      hit.valid <= s3_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_l.x   <= obj.center.x - ray_origin.x;
    s1_l.y   <= obj.center.y - ray_origin.y;
    s1_l.z   <= obj.center.z - ray_origin.z;
    s1_r     <= obj.radius;
    s1_color <= obj.color;

    // dir holds for the whole ray, so it is read directly here
    s2_tca   <= dot3(s1_l, ray_dir);
    s2_dd    <= dot3(ray_dir, ray_dir);
    s2_ll    <= dot3(s1_l, s1_l);
    s2_r2    <= dot_t'(s1_r) * dot_t'(s1_r);
    s2_color <= s1_color;

    // tca^2 against (L.L - r^2) * d.d, no square root needed
    s3_tca_pos <= (s2_tca > 0);
    s3_tca2    <= mul_wide(s2_tca, s2_tca);
    s3_cdd     <= mul_wide(s2_ll - s2_r2, s2_dd);
    s3_ll      <= s2_ll;
    s3_color   <= s2_color;

    // centers behind the camera never count as a hit
    hit.hit   <= s3_tca_pos && (s3_tca2 >= s3_cdd);
    hit.dist2 <= s3_ll;
    hit.color <= s3_color;
  end

endmodule

`default_nettype wire

// ==== tb_rtx.sv ====
`default_nettype none

`include "rtx_config.svh"

module tb_rtx;
  timeunit 1ns;
  timeprecision 1ps;

  import rt_math_pkg::*;
  import rt_scene_pkg::*;

  // small screen keeps full frames short
  localparam int WIDTH  = 16;
  localparam int HEIGHT = 8;
  localparam int NROWS  = 5;
  localparam int NOBJ   = `RTX_MAX_OBJS;

  logic        clk;
  logic        rst_n;
  camera_t     cam;
  obj_cnt_t    num_objs;
  sphere_t     obj;
  obj_idx_t    obj_idx;
  logic [15:0] rtx_pixel;
  logic [10:0] pixel_h;
  logic [9:0]  pixel_v;
  logic        ray_done;

  // stimulus table with one entry per test
  string    row_name [NROWS];
  camera_t  row_cam  [NROWS];
  obj_cnt_t row_num  [NROWS];
  sphere_t  row_objs [NROWS][NOBJ];
  int       row_npix [NROWS];

  // scene buffer model contents for the running row
  sphere_t     scene_mem [NOBJ];
  obj_idx_t    idx_prev;
  logic [31:0] lfsr_state;
  logic        table_ready;
  int          errors;
  int          checks;

  rtx_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_rtx_top (
    .clk(clk), .rst_n(rst_n), .cam(cam), .num_objs(num_objs), .obj(obj),
    .obj_idx(obj_idx), .rtx_pixel(rtx_pixel), .pixel_h(pixel_h),
    .pixel_v(pixel_v), .ray_done(ray_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // synchronous scene memory answers obj_idx one cycle later
  initial begin
    obj      = '0;
    idx_prev = '0;
    forever begin
      @(negedge clk);
      obj      = scene_mem[idx_prev];
      idx_prev = obj_idx;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one step per bit taken
  task automatic next_rand_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  function automatic camera_t make_cam(input int x, input int y, input int z, input int f);
    camera_t c;
    c.pos.x = coord_t'(x);
    c.pos.y = coord_t'(y);
    c.pos.z = coord_t'(z);
    c.focal = 12'(f);
    return c;
  endfunction

  function automatic sphere_t make_sphere(input int x, input int y, input int z,
                                          input int r, input logic [23:0] col);
    sphere_t s;
    s.center.x = coord_t'(x);
    s.center.y = coord_t'(y);
    s.center.z = coord_t'(z);
    s.radius   = 12'(r);
    s.color    = color_t'(col);
    return s;
  endfunction

  // ray rule in 64-bit integers
  // nearest L.L wins and the lower index takes a tie
  function automatic logic [15:0] expected_pixel(input int r, input int h, input int v);
    longint dx, dy, dz, lx, ly, lz;
    longint tca, dd, ll, rr, best_ll;
    int     best;
    color_t c;
    dx = longint'(h - WIDTH / 2);
    dy = longint'(HEIGHT / 2 - v);
    dz = longint'(row_cam[r].focal);
    dd = dx * dx + dy * dy + dz * dz;
    best = -1;
    best_ll = 0;
    for (int i = 0; i < int'(row_num[r]); i++) begin
      lx  = longint'($signed(row_objs[r][i].center.x)) - longint'($signed(row_cam[r].pos.x));
      ly  = longint'($signed(row_objs[r][i].center.y)) - longint'($signed(row_cam[r].pos.y));
      lz  = longint'($signed(row_objs[r][i].center.z)) - longint'($signed(row_cam[r].pos.z));
      tca = lx * dx + ly * dy + lz * dz;
      ll  = lx * lx + ly * ly + lz * lz;
      rr  = longint'(row_objs[r][i].radius);
      if (tca > 0 && tca * tca - (ll - rr * rr) * dd >= 0 && (best < 0 || ll < best_ll)) begin
        best    = i;
        best_ll = ll;
      end
    end
    if (best < 0) begin
      c = color_t'(`RTX_BG_COLOR);
    end else begin
      c = row_objs[r][best].color;
    end
    // RGB565 with red in the low bits
    return {c.b[7:3], c.g[7:2], c.r[7:3]};
  endfunction

  task automatic check_pixel(input logic [15:0] got, input logic [15:0] exp,
                             input int r, input int p);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH rtx_pixel row %0d pixel %0d: got 0x%h expected 0x%h", r, p, got, exp);
    end
  endtask

  task automatic check_pix(input pix_t got, input pix_t exp, input int r, input int p);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH pixel_h/pixel_v row %0d pixel %0d: got 0x%h/0x%h expected 0x%h/0x%h",
               r, p, got.h, got.v, exp.h, exp.v);
    end
  endtask

  task automatic build_table();
    logic [7:0] cr;
    logic [7:0] cg;
    logic [7:0] cb;
    for (int r = 0; r < NROWS; r++) begin
      for (int i = 0; i < NOBJ; i++) begin
        row_objs[r][i] = '0;
      end
    end
    // empty scene across a line boundary
    row_name[0] = "empty scene";
    row_cam[0]  = make_cam(0, 0, 0, 8);
    row_num[0]  = obj_cnt_t'(0);
    row_npix[0] = 24;
    // slot 0 would cover every pixel here if it were ever issued
    row_objs[0][0] = make_sphere(0, 0, 40, 30, 24'h10e010);
    // one sphere on the axis where edge pixels miss
    row_name[1] = "centered sphere";
    row_cam[1]  = make_cam(0, 0, 0, 8);
    row_num[1]  = obj_cnt_t'(1);
    row_npix[1] = WIDTH * HEIGHT;
    row_objs[1][0] = make_sphere(0, 0, 40, 12, 24'he03018);
    // obj1 and obj2 share L.L so obj1 must win the tie
    row_name[2] = "overlap and tie";
    row_cam[2]  = make_cam(0, 0, 0, 8);
    row_num[2]  = obj_cnt_t'(3);
    row_npix[2] = WIDTH * HEIGHT;
    row_objs[2][0] = make_sphere(0, 0, 60, 30, 24'hc04020);
    row_objs[2][1] = make_sphere(0, 0, 40, 10, 24'h20c040);
    row_objs[2][2] = make_sphere(0, 0, 40, 14, 24'h4020c0);
    // camera inside obj1 with the centers of obj0 and obj1 behind it
    row_name[3] = "behind camera";
    row_cam[3]  = make_cam(0, 0, 20, 8);
    row_num[3]  = obj_cnt_t'(3);
    row_npix[3] = WIDTH * HEIGHT;
    row_objs[3][0] = make_sphere(0, 0, -20, 30, 24'hff0000);
    row_objs[3][1] = make_sphere(0, 0, 10, 40, 24'h00ff00);
    row_objs[3][2] = make_sphere(0, 0, 100, 20, 24'h80a0f0);
    // full buffer running past the last pixel into the next frame
    row_name[4] = "full scene";
    row_cam[4]  = make_cam(1, -2, 0, 10);
    row_num[4]  = obj_cnt_t'(NOBJ);
    row_npix[4] = WIDTH * HEIGHT + 8;
    for (int i = 0; i < NOBJ; i++) begin
      next_rand_byte(cr);
      next_rand_byte(cg);
      next_rand_byte(cb);
      row_objs[4][i] = make_sphere((i % 4) * 10 - 15, (i / 4) * 8 - 4, 40 + 5 * i, 6 + i,
                                   {cr, cg, cb});
    end
  endtask

  // seen goes high on ray_done
  // gives up after limit cycles
  task automatic wait_ray_done(input int limit, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge clk);
      if (ray_done) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic run_row(input int r);
    pix_t exp_pix;
    bit   seen;
    int   start_err;
    int   limit;
    int   done_cnt;
    start_err = errors;
    done_cnt  = 0;
    @(negedge clk);
    rst_n    = 1'b0;
    cam      = row_cam[r];
    num_objs = row_num[r];
    for (int i = 0; i < NOBJ; i++) begin
      scene_mem[i] = row_objs[r][i];
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // a pixel takes num_objs + 8 cycles
    // doubled for slack
    limit = 2 * (int'(row_num[r]) + 8) + 8;
    for (int p = 0; p < row_npix[r]; p++) begin
      wait_ray_done(limit, seen);
      if (!seen) begin
        errors++;
        $display("row %0d: no ray_done for pixel %0d within %0d cycles", r, p, limit);
        break;
      end
      done_cnt++;
      exp_pix.h = 11'(p % WIDTH);
      exp_pix.v = 10'((p / WIDTH) % HEIGHT);
      check_pixel(rtx_pixel, expected_pixel(r, int'(exp_pix.h), int'(exp_pix.v)), r, p);
      check_pix(pix_t'({pixel_h, pixel_v}), exp_pix, r, p);
    end
    $display("row %0d (%s): %0d pixels, %0d errors", r, row_name[r], done_cnt,
             errors - start_err);
  endtask

  // bound follows from the per pixel latency of every row
  initial begin
    longint bound;
    wait (table_ready);
    bound = 0;
    for (int r = 0; r < NROWS; r++) begin
      bound += longint'(row_npix[r]) * (longint'(row_num[r]) + 8) + 16;
    end
    bound = bound * 2;
    #(bound * 4);
    $display("watchdog expired after %0d cycles, the run did not complete", bound);
    $display("sim failed");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    cam         = '0;
    num_objs    = '0;
    errors      = 0;
    checks      = 0;
    lfsr_state  = 32'h8eeae4e4;
    table_ready = 1'b0;
    for (int i = 0; i < NOBJ; i++) begin
      scene_mem[i] = '0;
    end
    build_table();
    table_ready = 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== trace_ctrl.sv ====
`default_nettype none

module trace_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rt_scene_pkg::obj_cnt_t num_objs,
  ray_if.sink                    ray,
  hit_if.sink                    hit,
  output rt_scene_pkg::obj_idx_t obj_idx,
  output logic                   obj_valid,
  output logic                   new_ray,
  output logic                   res_valid,
  output logic                   res_hit,
  output rt_scene_pkg::color_t   res_color
);
  import rt_math_pkg::*;
  import rt_scene_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_DRAIN, ST_DONE} state_t;

  state_t   state;
  // results returned for the current ray
  obj_cnt_t rcount;
  // empty scene wait, keeps the result behind the pixel delay line
  logic [1:0] settle;
  logic     armed;
  logic     res_d;

  // running nearest hit
  logic     best_valid;
  dot_t     best_dist;
  color_t   best_color;

  logic     better;
  logic     nxt_valid;
  color_t   nxt_color;
  logic     last_hit;
  logic     drain_done;

  // strict compare, earlier (lower index) object wins a tie
  always_comb begin
    better     = hit.valid && hit.hit && (!best_valid || hit.dist2 < best_dist);
    nxt_valid  = best_valid || better;
    nxt_color  = better ? hit.color : best_color;
    last_hit   = hit.valid && ((rcount + obj_cnt_t'(1)) == num_objs);
    drain_done = (state == ST_DRAIN) &&
                 (last_hit || (num_objs == '0 && settle == '0));
  end

  assign res_valid = (state == ST_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      obj_idx    <= '0;
      obj_valid  <= 1'b0;
      rcount     <= '0;
      settle     <= '0;
      best_valid <= 1'b0;
      res_hit    <= 1'b0;
      armed      <= 1'b0;
      res_d      <= 1'b0;
      new_ray    <= 1'b0;
    end else begin
      // first ray one cycle after reset release, then one per result
      armed     <= 1'b1;
      res_d     <= res_valid;
      new_ray   <= !armed || res_d;
      obj_valid <= 1'b0;

      if (hit.valid) begin
        rcount     <= rcount + obj_cnt_t'(1);
        best_valid <= nxt_valid;
      end

      case (state)
        ST_IDLE: begin
          if (ray.valid) begin
            rcount     <= '0;
            best_valid <= 1'b0;
            settle     <= 2'd3;
            if (num_objs == '0) begin
              state <= ST_DRAIN;
            end else begin
              // index 0 already sits on obj_idx, so it goes out now
              obj_valid <= 1'b1;
              if (num_objs == obj_cnt_t'(1)) begin
                state <= ST_DRAIN;
              end else begin
                obj_idx <= obj_idx_t'(1);
                state   <= ST_ISSUE;
              end
            end
          end
        end
        ST_ISSUE: begin
          obj_valid <= 1'b1;
          if ((obj_cnt_t'(obj_idx) + obj_cnt_t'(1)) == num_objs) begin
            obj_idx <= '0;
            state   <= ST_DRAIN;
          end else begin
            obj_idx <= obj_idx + obj_idx_t'(1);
          end
        end
        ST_DRAIN: begin
          if (settle != '0) begin
            settle <= settle - 2'd1;
          end
          if (drain_done) begin
            res_hit <= nxt_valid;
            state   <= ST_DONE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // distance and color payload of the nearest hit
  always_ff @(posedge clk) begin
    if (better) begin
      best_dist  <= hit.dist2;
      best_color <= hit.color;
    end
    if (drain_done) begin
      res_color <= nxt_color;
    end
  end

endmodule

`default_nettype wire
